// File: ExAluOperandPrep.sv
`timescale 1ns/1ps

`include "ExWideAlu_settings.svh"

module ExAluOperandPrep
(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         inValid,
	input  ExWideAluPkg::aluOp_t         inOp,
	input  ExWideAluPkg::aluTag_t        inTag,
	input  logic [`EX_WIDEALU_WIDTH-1:0] inA,
	input  logic [`EX_WIDEALU_WIDTH-1:0] inB,
	output logic                         prepValid,
	output ExWideAluPkg::aluOp_t         prepOp,
	output ExWideAluPkg::aluTag_t        prepTag,
	output logic [`EX_WIDEALU_WIDTH-1:0] addLA,
	output logic [`EX_WIDEALU_WIDTH-1:0] addLB,
	output logic [`EX_WIDEALU_WIDTH-1:0] addRA,
	output logic [`EX_WIDEALU_WIDTH-1:0] addRB
);

	import ExWideAluPkg::*;

	// valid stage flag.
	always_ff @(posedge clock)
	begin
		if (!rstN)
			prepValid <= 1'b0;
		else
			prepValid <= inValid;
	end

	//////////////////////////////
	// operand conditioning
	//////////////////////////////

	// left adder gives a+b, or ~a+b whose inverse is a-b.
	// right adder gives a+~b whose inverse is b-a.
	always_ff @(posedge clock)
	begin
		if (inValid)
		begin
			prepOp  <= inOp;
			prepTag <= inTag;
			addLA   <= (inOp == OpAdd) ? inA : ~inA;
			addLB   <= inB;
			addRA   <= inA;
			addRB   <= ~inB;	// both candidates every time.
		end
	end

endmodule

// File: ExAluResultMerge.sv
`timescale 1ns/1ps

`include "ExWideAlu_settings.svh"

module ExAluResultMerge
(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         prepValid,
	input  ExWideAluPkg::aluOp_t         prepOp,
	input  ExWideAluPkg::aluTag_t        prepTag,
	input  logic [`EX_WIDEALU_WIDTH-1:0] sumL,
	input  logic [`EX_WIDEALU_WIDTH-1:0] sumR,
	output logic                         mergeValid,
	output ExWideAluPkg::aluTag_t        mergeTag,
	output logic [`EX_WIDEALU_WIDTH-1:0] mergeResult,
	output logic                         mergeZero,
	output logic                         mergeNeg
);

	import ExWideAluPkg::*;

	logic [`EX_WIDEALU_WIDTH-1:0] result;
	logic                         isZero;
	logic                         isNeg;

	//////////////////////////////
	// result select
	//////////////////////////////

	always_comb
	begin
		case (prepOp)
			OpAdd:   result = sumL;
			OpSub:   result = ~sumL;	// undo the inverted a.
			OpRsub:  result = ~sumR;
			default: result = sumL;
		endcase
	end

	// flags from the chosen word.
	assign isZero = ~|result;
	assign isNeg  = result[`EX_WIDEALU_WIDTH-1];	// sign bit.

	always_ff @(posedge clock)
	begin
		if (!rstN)
			mergeValid <= 1'b0;
		else
			mergeValid <= prepValid;
	end

	// payload follows the valid flag.
	always_ff @(posedge clock)
	begin
		if (prepValid)
		begin
			mergeTag    <= prepTag;
			mergeResult <= result;
			mergeZero   <= isZero;
			mergeNeg    <= isNeg;
		end
	end

endmodule

// File: ExAluResultQueue.sv
`timescale 1ns/1ps

`include "ExWideAlu_settings.svh"

module ExAluResultQueue
(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         mergeValid,
	input  ExWideAluPkg::aluTag_t        mergeTag,
	input  logic [`EX_WIDEALU_WIDTH-1:0] mergeResult,
	input  logic                         mergeZero,
	input  logic                         mergeNeg,
	input  logic                         outCredit,
	output logic                         outValid,
	output ExWideAluPkg::aluTag_t        outTag,
	output logic [`EX_WIDEALU_WIDTH-1:0] outResult,
	output logic                         outZero,
	output logic                         outNeg,
	output logic                         creditRet
);

	import ExWideAluPkg::*;

	localparam int Depth = `EX_WIDEALU_IN_CREDITS;
	localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW  = $clog2(Depth + 1);
	localparam int CrdW  = $clog2(`EX_WIDEALU_OUT_CREDITS + 1);

	// entry storage.
	aluTag_t                      memTag    [Depth];
	logic [`EX_WIDEALU_WIDTH-1:0] memResult [Depth];
	logic                         memZero   [Depth];
	logic                         memNeg    [Depth];

	logic [PtrW-1:0] headPtr;
	logic [PtrW-1:0] tailPtr;
	logic [CntW-1:0] count;
	logic [CrdW-1:0] credits;	// sends still allowed downstream.

	logic empty;
	logic pop;
	logic bypass;
	logic memPop;
	logic push;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		if (ptr == PtrW'(Depth - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	//////////////////////////////
	// pop and push decisions
	//////////////////////////////

	assign empty  = (count == '0);
	assign pop    = (credits != '0) && (!empty || mergeValid);
	assign bypass = pop && empty;	// incoming entry skips storage.
	assign memPop = pop && !empty;
	assign push   = mergeValid && !bypass;

	always_ff @(posedge clock)
	begin
		if (push)
		begin
			memTag[tailPtr]    <= mergeTag;
			memResult[tailPtr] <= mergeResult;
			memZero[tailPtr]   <= mergeZero;
			memNeg[tailPtr]    <= mergeNeg;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			count   <= '0;
		end
		else
		begin
			if (push)
				tailPtr <= nextPtr(tailPtr);
			if (memPop)
				headPtr <= nextPtr(headPtr);
			case ({push, memPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none or both.
			endcase
		end
	end

	//////////////////////////////
	// downstream credits
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
			credits <= CrdW'(`EX_WIDEALU_OUT_CREDITS);
		else
		begin
			case ({pop, outCredit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// output slot, one result per send.
	always_ff @(posedge clock)
	begin
		if (!rstN)
			outValid <= 1'b0;
		else
			outValid <= pop;
	end

	always_ff @(posedge clock)
	begin
		if (pop)
		begin
			if (empty)
			begin
				outTag    <= mergeTag;
				outResult <= mergeResult;
				outZero   <= mergeZero;
				outNeg    <= mergeNeg;
			end
			else
			begin
				outTag    <= memTag[headPtr];
				outResult <= memResult[headPtr];
				outZero   <= memZero[headPtr];
				outNeg    <= memNeg[headPtr];
			end
		end
	end

	// each send frees one upstream slot.
	assign creditRet = outValid;

endmodule

// File: ExCsAdd90F.sv
`timescale 1ns/1ps

module ExCsAdd90F
(
	input  logic [89:0] valA,
	input  logic [89:0] valB,
	output logic [89:0] valC
);

	//////////////////////////////
	// block sums
	//////////////////////////////

	// lowest block sees no carry-in, so one version only.
	logic [16:0] sumA0;
	logic [16:0] sumB0;
	logic [16:0] sumB1;
	logic [16:0] sumC0;
	logic [16:0] sumC1;
	logic [16:0] sumD0;
	logic [16:0] sumD1;
	logic [16:0] sumE0;
	logic [16:0] sumE1;
	logic [9:0]  sumF0;	// top carry is dropped.
	logic [9:0]  sumF1;

	// first select level, blocks taken in pairs.
	logic [32:0] pairA0;
	logic [32:0] pairB0;
	logic [32:0] pairB1;
	logic [25:0] pairC0;
	logic [25:0] pairC1;

	// second select level.
	logic [64:0] lowHalf;

	always_comb
	begin
		sumA0 = {1'b0, valA[15:0]} + {1'b0, valB[15:0]};
		sumB0 = {1'b0, valA[31:16]} + {1'b0, valB[31:16]};
		sumB1 = {1'b0, valA[31:16]} + {1'b0, valB[31:16]} + 17'd1;
		sumC0 = {1'b0, valA[47:32]} + {1'b0, valB[47:32]};
		sumC1 = {1'b0, valA[47:32]} + {1'b0, valB[47:32]} + 17'd1;
		sumD0 = {1'b0, valA[63:48]} + {1'b0, valB[63:48]};
		sumD1 = {1'b0, valA[63:48]} + {1'b0, valB[63:48]} + 17'd1;
		sumE0 = {1'b0, valA[79:64]} + {1'b0, valB[79:64]};
		sumE1 = {1'b0, valA[79:64]} + {1'b0, valB[79:64]} + 17'd1;
		sumF0 = valA[89:80] + valB[89:80];
		sumF1 = valA[89:80] + valB[89:80] + 10'd1;

		// pick upper block of each pair by the lower block's carry.
		pairA0 = {sumA0[16] ? sumB1 : sumB0, sumA0[15:0]};
		pairB0 = {sumC0[16] ? sumD1 : sumD0, sumC0[15:0]};
		pairB1 = {sumC1[16] ? sumD1 : sumD0, sumC1[15:0]};
		pairC0 = {sumE0[16] ? sumF1 : sumF0, sumE0[15:0]};
		pairC1 = {sumE1[16] ? sumF1 : sumF0, sumE1[15:0]};

		// join the halves, carry out of bit 63 steers the top.
		lowHalf = {pairA0[32] ? pairB1 : pairB0, pairA0[31:0]};
		valC    = {lowHalf[64] ? pairC1 : pairC0, lowHalf[63:0]};
	end

endmodule

// File: ExWideAluPkg.sv
package ExWideAluPkg;

	//////////////////////////////
	// request fields
	//////////////////////////////

	// opcode of a request.
	typedef enum logic [1:0]
	{
		OpAdd  = 2'd0,	// a plus b.
		OpSub  = 2'd1,	// a minus b.
		OpRsub = 2'd2	// b minus a.
	} aluOp_t;

	// request tag, passed through untouched.
	typedef logic [3:0] aluTag_t;

endpackage

// File: ExWideAluTop.sv
`timescale 1ns/1ps

`include "ExWideAlu_settings.svh"

module ExWideAluTop
(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         inValid,
	input  ExWideAluPkg::aluOp_t         inOp,
	input  ExWideAluPkg::aluTag_t        inTag,
	input  logic [`EX_WIDEALU_WIDTH-1:0] inA,
	input  logic [`EX_WIDEALU_WIDTH-1:0] inB,
	input  logic                         outCredit,
	output logic                         creditRet,
	output logic                         outValid,
	output ExWideAluPkg::aluTag_t        outTag,
	output logic [`EX_WIDEALU_WIDTH-1:0] outResult,
	output logic                         outZero,
	output logic                         outNeg
);

	import ExWideAluPkg::*;

	// prep stage.
	logic                         prepValid;
	aluOp_t                       prepOp;
	aluTag_t                      prepTag;
	logic [`EX_WIDEALU_WIDTH-1:0] addLA;
	logic [`EX_WIDEALU_WIDTH-1:0] addLB;
	logic [`EX_WIDEALU_WIDTH-1:0] addRA;
	logic [`EX_WIDEALU_WIDTH-1:0] addRB;

	// adder sums.
	logic [`EX_WIDEALU_WIDTH-1:0] sumL;
	logic [`EX_WIDEALU_WIDTH-1:0] sumR;

	// merge stage.
	logic                         mergeValid;
	aluTag_t                      mergeTag;
	logic [`EX_WIDEALU_WIDTH-1:0] mergeResult;
	logic                         mergeZero;
	logic                         mergeNeg;

	ExAluOperandPrep prep
	(
		.clock     (clock),
		.rstN      (rstN),
		.inValid   (inValid),
		.inOp      (inOp),
		.inTag     (inTag),
		.inA       (inA),
		.inB       (inB),
		.prepValid (prepValid),
		.prepOp    (prepOp),
		.prepTag   (prepTag),
		.addLA     (addLA),
		.addLB     (addLB),
		.addRA     (addRA),
		.addRB     (addRB)
	);

	//////////////////////////////
	// adders side by side
	//////////////////////////////

	ExCsAdd90F addLeft
	(
		.valA (addLA),
		.valB (addLB),
		.valC (sumL)
	);

	ExCsAdd90F addRight
	(
		.valA (addRA),
		.valB (addRB),
		.valC (sumR)
	);

	ExAluResultMerge merge
	(
		.clock       (clock),
		.rstN        (rstN),
		.prepValid   (prepValid),
		.prepOp      (prepOp),
		.prepTag     (prepTag),
		.sumL        (sumL),
		.sumR        (sumR),
		.mergeValid  (mergeValid),
		.mergeTag    (mergeTag),
		.mergeResult (mergeResult),
		.mergeZero   (mergeZero),
		.mergeNeg    (mergeNeg)
	);

	ExAluResultQueue queue
	(
		.clock       (clock),
		.rstN        (rstN),
		.mergeValid  (mergeValid),
		.mergeTag    (mergeTag),
		.mergeResult (mergeResult),
		.mergeZero   (mergeZero),
		.mergeNeg    (mergeNeg),
		.outCredit   (outCredit),
		.outValid    (outValid),
		.outTag      (outTag),
		.outResult   (outResult),
		.outZero     (outZero),
		.outNeg      (outNeg),
		.creditRet   (creditRet)
	);

endmodule

// File: ExWideAlu_settings.svh
`ifndef EX_WIDEALU_SETTINGS_SVH
`define EX_WIDEALU_SETTINGS_SVH

//////////////////////////////
// datapath
//////////////////////////////

// operand and result width.
`define EX_WIDEALU_WIDTH 90

//////////////////////////////
// flow control
//////////////////////////////

// credits held by the source after reset, also the queue depth.
`define EX_WIDEALU_IN_CREDITS 4

// credits held for the sink after reset.
`define EX_WIDEALU_OUT_CREDITS 2

`endif

// File: files.f
+incdir+.
ExWideAluPkg.sv
ExCsAdd90F.sv
ExAluOperandPrep.sv
ExAluResultMerge.sv
ExAluResultQueue.sv
ExWideAluTop.sv
tb_ExWideAlu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module tb_ExWideAlu \
	-Mdir obj_dir \
	-o simTb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/simTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: tb_ExWideAlu.sv
`timescale 1ns/1ps

`include "ExWideAlu_settings.svh"

module tb_ExWideAlu;

	import ExWideAluPkg::*;

	localparam int W         = `EX_WIDEALU_WIDTH;
	localparam int InCrd     = `EX_WIDEALU_IN_CREDITS;
	localparam int OutCrd    = `EX_WIDEALU_OUT_CREDITS;
	localparam int NumChecks = 400;
	localparam int WaitLimit = 500;	// cycles, longer than any sink stall.

	logic         clock = 1'b0;
	logic         rstN;
	logic         inValid;
	aluOp_t       inOp;
	aluTag_t      inTag;
	logic [W-1:0] inA;
	logic [W-1:0] inB;
	logic         outCredit;
	logic         creditRet;
	logic         outValid;
	aluTag_t      outTag;
	logic [W-1:0] outResult;
	logic         outZero;
	logic         outNeg;

	// scoreboard, oldest request first.
	logic [W-1:0] expResult [$];
	aluTag_t      expTag    [$];

	int          inCredits;
	int          sentReq;
	int          sentOut;
	int          returned;
	int          owed;	// results the sink still has to credit.
	int          checked;
	int          stallLeft;
	logic        rstSeen;
	logic [31:0] stimState;
	logic [31:0] sinkState;
	aluTag_t     nextTag;

	ExWideAluTop uut
	(
		.clock     (clock),
		.rstN      (rstN),
		.inValid   (inValid),
		.inOp      (inOp),
		.inTag     (inTag),
		.inA       (inA),
		.inB       (inB),
		.outCredit (outCredit),
		.creditRet (creditRet),
		.outValid  (outValid),
		.outTag    (outTag),
		.outResult (outResult),
		.outZero   (outZero),
		.outNeg    (outNeg)
	);

	initial
	begin
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// modulo 2^90 by truncation to W bits.
	function automatic logic [W-1:0] expectedResult(input aluOp_t op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		case (op)
			OpSub:   return a - b;
			OpRsub:  return b - a;
			default: return a + b;
		endcase
	endfunction

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	// three 30-bit draws, upper LCG bits only.
	task automatic drawOperand(output logic [W-1:0] val);
		logic [29:0] part [3];
		for (int i = 0; i < 3; i++)
		begin
			stimState = lcgStep(stimState);
			part[i] = stimState[31:2];
		end
		val = {part[0], part[1], part[2]};
	endtask

	task automatic idleCycle();
		@(posedge clock);
		inValid <= 1'b0;
	endtask

	task automatic sendRequest(input aluOp_t op, input logic [W-1:0] a, input logic [W-1:0] b);
		int waited;
		waited = 0;
		@(posedge clock);
		while (inCredits == 0)
		begin
			inValid <= 1'b0;
			if (waited >= WaitLimit)
				stopOnError("no input credit came back within the wait limit");
			else
			begin
				waited++;
				@(posedge clock);
			end
		end
		inValid   <= 1'b1;
		inOp      <= op;
		inTag     <= nextTag;
		inA       <= a;
		inB       <= b;
		inCredits = inCredits - 1;
		expResult.push_back(expectedResult(op, a, b));
		expTag.push_back(nextTag);
		nextTag = nextTag + 4'd1;
		sentReq++;
	endtask

	//////////////////////////////
	// response checks
	//////////////////////////////

	always @(negedge clock)
	begin
		if (!rstN || !rstSeen)
		begin
			assert (!outValid && !creditRet)
			else stopOnError($sformatf("Mismatch at %0t: outValid %b creditRet %b at reset",
				$time, outValid, creditRet));
		end
		rstSeen = rstN;
		assert (creditRet == outValid)
		else stopOnError($sformatf("Mismatch at %0t: creditRet %b while outValid %b",
			$time, creditRet, outValid));
		if (outValid)
		begin
			sentOut++;
			assert (sentOut <= OutCrd + returned)
			else stopOnError("more results sent than output credits allowed");
			if (expResult.size() == 0)
				stopOnError("result came out with no request pending");
			else
			begin
				assert (outTag == expTag[0])
				else stopOnError($sformatf("Mismatch at %0t: tag %0d, expected %0d",
					$time, outTag, expTag[0]));
				assert (outResult == expResult[0])
				else stopOnError($sformatf("Mismatch at %0t: tag %0d result %h, expected %h",
					$time, outTag, outResult, expResult[0]));
				assert (outZero == (expResult[0] == '0))
				else stopOnError($sformatf("Mismatch at %0t: tag %0d zero flag %b",
					$time, outTag, outZero));
				assert (outNeg == expResult[0][W-1])
				else stopOnError($sformatf("Mismatch at %0t: tag %0d negative flag %b",
					$time, outTag, outNeg));
				void'(expResult.pop_front());
				void'(expTag.pop_front());
				owed++;
				checked++;
			end
		end
		if (outCredit)
			returned++;	// used by the DUT on the next edge.
		if (creditRet)
			inCredits = inCredits + 1;
		assert (inCredits >= 0 && inCredits <= InCrd)
		else stopOnError($sformatf("input credit count out of range: %0d", inCredits));
	end

	// sink, random returns and stalls with no returns.
	always @(posedge clock)
	begin
		if (!rstN)
			outCredit <= 1'b0;
		else if (stallLeft > 0)
		begin
			stallLeft--;
			outCredit <= 1'b0;
		end
		else
		begin
			sinkState = lcgStep(sinkState);
			if (sinkState[31:26] == 6'd0)
			begin
				stallLeft = 16 + int'(sinkState[20:16]);
				outCredit <= 1'b0;
			end
			else if (owed > 0 && sinkState[25])
			begin
				outCredit <= 1'b1;
				owed--;
			end
			else
				outCredit <= 1'b0;
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] maxPos;
		logic [W-1:0] minNeg;
		aluOp_t       op;
		int           waited;

		rstN      = 1'b0;
		inValid   = 1'b0;
		inOp      = OpAdd;
		inTag     = '0;
		inA       = '0;
		inB       = '0;
		outCredit = 1'b0;
		inCredits = InCrd;
		rstSeen   = 1'b0;
		stimState = 32'd73260;
		sinkState = 32'd73260;
		nextTag   = '0;
		maxPos    = {1'b0, {(W-1){1'b1}}};
		minNeg    = {1'b1, {(W-1){1'b0}}};

		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		idleCycle();

		// directed corners.
		drawOperand(a);
		sendRequest(OpSub, a, a);	// zero with flag.
		sendRequest(OpAdd, '0, '0);
		sendRequest(OpSub, '0, '0);
		sendRequest(OpRsub, '0, '0);
		sendRequest(OpAdd, '1, '1);
		sendRequest(OpSub, '1, '1);
		sendRequest(OpRsub, '0, '1);
		sendRequest(OpAdd, maxPos, W'(1));	// crosses into the sign bit.
		sendRequest(OpSub, minNeg, W'(1));
		sendRequest(OpSub, '0, W'(1));
		sendRequest(OpRsub, W'(1), minNeg);

		while (sentReq < NumChecks)
		begin
			stimState = lcgStep(stimState);
			case (stimState[31:16] % 16'd3)
				16'd0:   op = OpAdd;
				16'd1:   op = OpSub;
				default: op = OpRsub;
			endcase
			drawOperand(a);
			drawOperand(b);
			stimState = lcgStep(stimState);
			if (stimState[31:28] == 4'd0)
				b = a;
			sendRequest(op, a, b);
			stimState = lcgStep(stimState);
			if (stimState[31:30] == 2'd0)
				idleCycle();
		end
		idleCycle();

		waited = 0;
		while (checked < NumChecks)
		begin
			if (waited >= WaitLimit * 4)
				stopOnError("timed out waiting for the remaining results");
			else
			begin
				waited++;
				@(posedge clock);
			end
		end

		// unit drained, all upstream credits should be back.
		waited = 0;
		while (inCredits != InCrd)
		begin
			if (waited >= WaitLimit)
				stopOnError("input credits did not return to their reset count");
			else
			begin
				waited++;
				@(posedge clock);
			end
		end
		$display("test passed");
		$finish;
	end

endmodule
